/* hdl/pcoeff_defines.svh */
`ifndef PCOEFF_DEFINES_SVH
`define PCOEFF_DEFINES_SVH

// Per-batch widths
`define PCOEFF_COUNT_BITS 10
`define PCOEFF_SUM_BITS (`PCOEFF_COUNT_BITS + 8)
`define PERMUTE_COUNT 4

// Result FIFO sizing, 16 entries
`define RESULT_FIFO_DEPTH_LOG2 4
`define RESULT_FIFO_MARGIN 4

// AXI4-Lite byte offsets
`define REG_TOP0 8'h00
`define REG_TOP1 8'h04
`define REG_TOP2 8'h08
`define REG_TOP3 8'h0C
`define REG_BATCHES 8'h10
`define REG_BOTS 8'h14

`endif

/* hdl/pcoeffPkg.sv */
`include "pcoeff_defines.svh"

package pcoeffPkg;

    // Bot with its permutation mask, host side
    typedef struct packed {
        logic valid;
        logic [127:0] bot;
        logic [`PERMUTE_COUNT-1:0] permuteMask;
        logic lastOfBatch;
    } botIn_t;

    // One permuted copy heading for the aggregator
    typedef struct packed {
        logic valid;
        logic [127:0] bot;
        logic lastOfBatch;
    } permutedBot_t;

    typedef struct packed {
        logic [`PCOEFF_SUM_BITS-1:0] sum;
        logic [`PCOEFF_COUNT_BITS-1:0] count;
    } pcoeffResult_t;

    // Master-driven AXI4-Lite signals
    typedef struct packed {
        logic awvalid;
        logic [7:0] awaddr;
        logic wvalid;
        logic [31:0] wdata;
        logic [3:0] wstrb;
        logic bready;
        logic arvalid;
        logic [7:0] araddr;
        logic rready;
    } axiLiteReq_t;

    // Slave-driven AXI4-Lite signals
    typedef struct packed {
        logic awready;
        logic wready;
        logic bvalid;
        logic [1:0] bresp;
        logic arready;
        logic rvalid;
        logic [31:0] rdata;
        logic [1:0] rresp;
    } axiLiteRsp_t;

endpackage

/* hdl/botPermuter.sv */
`timescale 1ns/1ns

`include "pcoeff_defines.svh"

module botPermuter import pcoeffPkg::*; (
    input logic clk,
    input logic rst,
    input botIn_t botIn,
    output logic botReady,
    input logic holdOff,
    output permutedBot_t permOut
);

    logic [127:0] botReg;
    logic [`PERMUTE_COUNT-1:0] maskReg;
    logic [`PERMUTE_COUNT-1:0] lowBit;
    logic [`PERMUTE_COUNT-1:0] maskNext;
    logic lastReg;
    logic armed;
    logic busy;
    logic emitting;
    logic accept;

    // Truth table index bit k is the value of variable k
    function automatic logic [127:0] swapVariables(
        input logic [127:0] truthTable,
        input logic swap01,
        input logic swap23
    );
        logic [6:0] idx;
        logic [6:0] src;
        logic [127:0] res;
        for (int i = 0; i < 128; i++) begin
            idx = 7'(i);
            src = idx;
            if (swap01) begin
                src[1:0] = {idx[0], idx[1]};
            end
            if (swap23) begin
                src[3:2] = {idx[2], idx[3]};
            end
            res[i] = truthTable[src];
        end
        return res;
    endfunction

    // A pending marker keeps lastReg set with an empty mask
    assign busy = (|maskReg) || lastReg;
    assign emitting = busy && !holdOff;
    assign botReady = armed && !busy && !holdOff;
    assign accept = botIn.valid && botReady;

    // Lowest remaining mask bit picks the permutation
    assign lowBit = maskReg & (~maskReg + 1'b1);
    assign maskNext = maskReg & ~lowBit;

    assign permOut.valid = emitting && (|maskReg);
    assign permOut.bot = swapVariables(botReg, lowBit[1] | lowBit[3], lowBit[2] | lowBit[3]);
    assign permOut.lastOfBatch = emitting && lastReg && (maskNext == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            armed <= 1'b0;
            maskReg <= '0;
            lastReg <= 1'b0;
        end else begin
            armed <= 1'b1;
            if (accept) begin
                maskReg <= botIn.permuteMask;
                lastReg <= botIn.lastOfBatch;
            end else if (emitting) begin
                maskReg <= maskNext;
                if (maskNext == '0) begin
                    lastReg <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            botReg <= botIn.bot;
        end
    end

endmodule

/* hdl/pcoeffAggregator.sv */
`timescale 1ns/1ns

`include "pcoeff_defines.svh"

module pcoeffAggregator import pcoeffPkg::*; (
    input logic clk,
    input logic rst,
    input logic [127:0] sharedTop,
    input permutedBot_t permIn,
    output logic resultWrite,
    output pcoeffResult_t resultOut,
    output logic botCounted
);

    localparam int SUM_BITS = `PCOEFF_SUM_BITS;
    localparam int COUNT_BITS = `PCOEFF_COUNT_BITS;

    logic s1Valid;
    logic s1Last;
    logic [7:0] s1Pop;
    logic [SUM_BITS-1:0] sumAcc;
    logic [COUNT_BITS-1:0] countAcc;
    logic [SUM_BITS-1:0] sumNext;
    logic [COUNT_BITS-1:0] countNext;

    // Ones in a 128 bit word, at most 128
    function automatic logic [7:0] popCount128(input logic [127:0] word);
        logic [7:0] total;
        total = '0;
        for (int i = 0; i < 128; i++) begin
            total = total + 8'(word[i]);
        end
        return total;
    endfunction

    assign botCounted = permIn.valid;

    // Stage 1
    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s1Last <= 1'b0;
        end else begin
            s1Valid <= permIn.valid;
            s1Last <= permIn.lastOfBatch;
        end
        s1Pop <= popCount128(permIn.bot & sharedTop);
    end

    // Running totals including the item in stage 1
    assign sumNext = s1Valid ? sumAcc + SUM_BITS'(s1Pop) : sumAcc;
    assign countNext = countAcc + COUNT_BITS'(s1Valid);

    // Stage 2, closes the batch on lastOfBatch
    always_ff @(posedge clk) begin
        if (rst) begin
            sumAcc <= '0;
            countAcc <= '0;
            resultWrite <= 1'b0;
        end else begin
            resultWrite <= s1Last;
            if (s1Last) begin
                sumAcc <= '0;
                countAcc <= '0;
            end else begin
                sumAcc <= sumNext;
                countAcc <= countNext;
            end
        end
        if (s1Last) begin
            resultOut.sum <= sumNext;
            resultOut.count <= countNext;
        end
    end

endmodule

/* hdl/resultFifo.sv */
`timescale 1ns/1ns

`include "pcoeff_defines.svh"

module resultFifo import pcoeffPkg::*; (
    input logic clk,
    input logic rst,
    input logic writeEnable,
    input pcoeffResult_t dataIn,
    output logic almostFull,
    input logic readEnable,
    output pcoeffResult_t dataOut,
    output logic empty
);

    localparam int DEPTH_LOG2 = `RESULT_FIFO_DEPTH_LOG2;
    localparam int DEPTH = 1 << DEPTH_LOG2;
    localparam logic [DEPTH_LOG2:0] CAPACITY = {1'b1, {DEPTH_LOG2{1'b0}}};
    localparam logic [DEPTH_LOG2:0] ALMOST_LEVEL =
        CAPACITY - (DEPTH_LOG2 + 1)'(`RESULT_FIFO_MARGIN);

    pcoeffResult_t mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wrPtr;
    logic [DEPTH_LOG2-1:0] rdPtr;
    logic [DEPTH_LOG2:0] count;
    logic doWrite;
    logic doRead;

    assign empty = (count == '0);
    assign almostFull = (count >= ALMOST_LEVEL);
    assign doWrite = writeEnable && (count != CAPACITY);
    assign doRead = readEnable && !empty;

    // Head entry shown without a read latency
    assign dataOut = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doWrite) begin
            mem[wrPtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doWrite) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doRead) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({doWrite, doRead})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

/* hdl/pcoeffConfigRegs.sv */
`timescale 1ns/1ns

`include "pcoeff_defines.svh"

module pcoeffConfigRegs import pcoeffPkg::*; (
    input logic clk,
    input logic rst,
    input axiLiteReq_t axiReq,
    output axiLiteRsp_t axiRsp,
    output logic [127:0] sharedTop,
    input logic batchDone,
    input logic botCounted
);

    localparam logic [1:0] RESP_OKAY = 2'b00;

    logic [31:0] topWords [4];
    logic [31:0] batchCount;
    logic [31:0] botCount;
    logic bvalidReg;
    logic rvalidReg;
    logic [31:0] rdataReg;
    logic writeAccept;
    logic readAccept;
    logic writeHit;
    logic [1:0] writeIndex;
    logic [31:0] readValue;

    // Address and data taken together, one response outstanding
    assign writeAccept = axiReq.awvalid && axiReq.wvalid && !bvalidReg;
    assign readAccept = axiReq.arvalid && !rvalidReg;

    always_comb begin
        writeHit = 1'b1;
        writeIndex = 2'd0;
        case (axiReq.awaddr)
            `REG_TOP0: writeIndex = 2'd0;
            `REG_TOP1: writeIndex = 2'd1;
            `REG_TOP2: writeIndex = 2'd2;
            `REG_TOP3: writeIndex = 2'd3;
            // Counters and holes ignore writes
            default: writeHit = 1'b0;
        endcase
    end

    always_comb begin
        case (axiReq.araddr)
            `REG_TOP0: readValue = topWords[0];
            `REG_TOP1: readValue = topWords[1];
            `REG_TOP2: readValue = topWords[2];
            `REG_TOP3: readValue = topWords[3];
            `REG_BATCHES: readValue = batchCount;
            `REG_BOTS: readValue = botCount;
            default: readValue = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < 4; w++) begin
                topWords[w] <= '0;
            end
            batchCount <= '0;
            botCount <= '0;
            bvalidReg <= 1'b0;
            rvalidReg <= 1'b0;
        end else begin
            if (writeAccept && writeHit) begin
                for (int b = 0; b < 4; b++) begin
                    if (axiReq.wstrb[b]) begin
                        topWords[writeIndex][8*b +: 8] <= axiReq.wdata[8*b +: 8];
                    end
                end
            end
            if (writeAccept) begin
                bvalidReg <= 1'b1;
            end else if (axiReq.bready) begin
                bvalidReg <= 1'b0;
            end
            if (readAccept) begin
                rvalidReg <= 1'b1;
            end else if (axiReq.rready) begin
                rvalidReg <= 1'b0;
            end
            if (batchDone) begin
                batchCount <= batchCount + 1'b1;
            end
            if (botCounted) begin
                botCount <= botCount + 1'b1;
            end
        end
        if (readAccept) begin
            rdataReg <= readValue;
        end
    end

    assign sharedTop = {topWords[3], topWords[2], topWords[1], topWords[0]};

    always_comb begin
        axiRsp.awready = writeAccept;
        axiRsp.wready = writeAccept;
        axiRsp.bvalid = bvalidReg;
        axiRsp.bresp = RESP_OKAY;
        axiRsp.arready = !rvalidReg;
        axiRsp.rvalid = rvalidReg;
        axiRsp.rdata = rdataReg;
        axiRsp.rresp = RESP_OKAY;
    end

endmodule

/* hdl/aggregatingPermutePipeline.sv */
`timescale 1ns/1ns

module aggregatingPermutePipeline import pcoeffPkg::*; (
    input logic clk,
    input logic rst,
    input botIn_t botIn,
    output logic botReady,
    input logic grabResults,
    output logic resultsAvailable,
    output pcoeffResult_t result,
    input axiLiteReq_t axiReq,
    output axiLiteRsp_t axiRsp
);

    logic [127:0] sharedTop;
    permutedBot_t permutedBot;
    pcoeffResult_t aggregateResult;
    logic resultWrite;
    logic botCounted;
    logic fifoAlmostFull;
    logic fifoEmpty;

    pcoeffConfigRegs i_pcoeffConfigRegs (
        .clk(clk),
        .rst(rst),
        .axiReq(axiReq),
        .axiRsp(axiRsp),
        .sharedTop(sharedTop),
        .batchDone(resultWrite),
        .botCounted(botCounted)
    );

    // Almost full stalls the permuter before the FIFO can overflow
    botPermuter i_botPermuter (
        .clk(clk),
        .rst(rst),
        .botIn(botIn),
        .botReady(botReady),
        .holdOff(fifoAlmostFull),
        .permOut(permutedBot)
    );

    pcoeffAggregator i_pcoeffAggregator (
        .clk(clk),
        .rst(rst),
        .sharedTop(sharedTop),
        .permIn(permutedBot),
        .resultWrite(resultWrite),
        .resultOut(aggregateResult),
        .botCounted(botCounted)
    );

    resultFifo i_resultFifo (
        .clk(clk),
        .rst(rst),
        .writeEnable(resultWrite),
        .dataIn(aggregateResult),
        .almostFull(fifoAlmostFull),
        .readEnable(grabResults),
        .dataOut(result),
        .empty(fifoEmpty)
    );

    assign resultsAvailable = !fifoEmpty;

endmodule

/* bench/aggregatingPermutePipeline_chk.sv */
`timescale 1ns/1ns

`include "pcoeff_defines.svh"

module aggregatingPipeline_chk import pcoeffPkg::*; (
    input logic clk,
    input logic rst,
    input logic botReady,
    input logic resultsAvailable,
    input logic grabResults,
    input logic resultWrite,
    input pcoeffResult_t result,
    input axiLiteReq_t axiReq,
    input axiLiteRsp_t axiRsp
);

    localparam int DEPTH = 1 << `RESULT_FIFO_DEPTH_LOG2;
    localparam int ALMOST_LEVEL = DEPTH - `RESULT_FIFO_MARGIN;

    // Read by the testbench at the end of the run
    int failCount = 0;
    // FIFO fill level seen from its write strobe and the host grabs
    int occupancy;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(resultWrite)
                - int'(grabResults && resultsAvailable);
        end
    end

    emptyQuiet: assert property (@(posedge clk) disable iff (rst)
        resultsAvailable == (occupancy != 0))
        else begin
            $error("resultsAvailable does not match the result FIFO fill level");
            failCount++;
        end

    // Permuter must not take a bot near FIFO overflow
    stallNearFull: assert property (@(posedge clk) disable iff (rst)
        (occupancy >= ALMOST_LEVEL) |-> !botReady)
        else begin
            $error("botReady high while the result FIFO is almost full");
            failCount++;
        end

    noOverflow: assert property (@(posedge clk) disable iff (rst)
        resultWrite |-> (occupancy < DEPTH))
        else begin
            $error("result written while the result FIFO is full");
            failCount++;
        end

    bvalidHeld: assert property (@(posedge clk) disable iff (rst)
        axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
        else begin
            $error("bvalid dropped before bready");
            failCount++;
        end

    rvalidHeld: assert property (@(posedge clk) disable iff (rst)
        axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid)
        else begin
            $error("rvalid dropped before rready");
            failCount++;
        end

    // Head entry may only move on a grab
    resultHeld: assert property (@(posedge clk) disable iff (rst)
        resultsAvailable && !grabResults |=> $stable(result))
        else begin
            $error("result changed without grabResults");
            failCount++;
        end

endmodule

bind aggregatingPermutePipeline aggregatingPipeline_chk i_aggregatingPipelineChk (
    .clk(clk),
    .rst(rst),
    .botReady(botReady),
    .resultsAvailable(resultsAvailable),
    .grabResults(grabResults),
    .resultWrite(resultWrite),
    .result(result),
    .axiReq(axiReq),
    .axiRsp(axiRsp)
);

/* bench/aggregatingPermutePipelineTb.sv */
`timescale 1ns/1ns

`include "pcoeff_defines.svh"

module aggregatingPermutePipelineTb import pcoeffPkg::*; ();

    // One row of the stimulus table
    typedef struct packed {
        logic [2:0] test;
        logic [127:0] bot;
        logic [3:0] mask;
        logic last;
    } stimEntry_t;

    logic clk;
    logic rst;
    botIn_t botIn;
    logic botReady;
    logic grabResults;
    logic resultsAvailable;
    pcoeffResult_t result;
    axiLiteReq_t axiReq;
    axiLiteRsp_t axiRsp;

    stimEntry_t stimTable[$];
    logic [31:0] topTable [8][4];
    pcoeffResult_t expQ[$];
    integer seed;
    int checks;
    int errors;
    int cycleCount;
    int cycleLimit;
    int expItems;
    int expBatches;
    logic stallSeen;
    logic sendDone;

    aggregatingPermutePipeline i_aggregatingPermutePipeline (
        .clk(clk),
        .rst(rst),
        .botIn(botIn),
        .botReady(botReady),
        .grabResults(grabResults),
        .resultsAvailable(resultsAvailable),
        .result(result),
        .axiReq(axiReq),
        .axiRsp(axiRsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        cycleCount = 0;
        @(posedge clk);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d clock cycles", cycleCount);
        $display("Checks failed");
        $finish;
    end

    // Swapping two variables exchanges the entries whose two index bits differ
    function automatic logic [127:0] permuteRef(
        input logic [127:0] tt,
        input logic swap01,
        input logic swap23
    );
        logic [127:0] res;
        int j;
        for (int i = 0; i < 128; i++) begin
            j = i;
            if (swap01 && (i[0] != i[1])) begin
                j = j ^ 3;
            end
            if (swap23 && (i[2] != i[3])) begin
                j = j ^ 12;
            end
            res[i] = tt[j];
        end
        return res;
    endfunction

    function automatic string testName(input logic [2:0] test);
        case (test)
            3'd1: return "reset and register access";
            3'd2: return "identity mask batch";
            3'd3: return "mixed masks";
            3'd4: return "batch boundaries";
            3'd5: return "back-pressure";
            default: return "unknown";
        endcase
    endfunction

    task automatic checkValue(
        input string what,
        input logic [63:0] got,
        input logic [63:0] expected
    );
        checks++;
        assert (got === expected) else begin
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic addEntry(input logic [2:0] test, input logic [3:0] mask, input logic last);
        stimEntry_t e;
        e.test = test;
        e.bot = {$random(seed), $random(seed), $random(seed), $random(seed)};
        e.mask = mask;
        e.last = last;
        stimTable.push_back(e);
    endtask

    task automatic buildTable();
        for (int t = 2; t <= 5; t++) begin
            for (int w = 0; w < 4; w++) begin
                topTable[t][w] = $random(seed);
            end
        end
        topTable[4][0] = 32'hffff_ffff;
        topTable[4][1] = 32'h0000_0000;
        topTable[4][2] = 32'h0f0f_0f0f;
        topTable[4][3] = 32'haaaa_5555;
        for (int k = 0; k < 5; k++) begin
            addEntry(3'd2, 4'b0001, k == 4);
        end
        addEntry(3'd3, 4'b1111, 1'b0);
        addEntry(3'd3, 4'b0110, 1'b0);
        addEntry(3'd3, 4'b1010, 1'b0);
        addEntry(3'd3, 4'b0011, 1'b0);
        addEntry(3'd3, 4'b1000, 1'b1);
        addEntry(3'd4, 4'b0001, 1'b0);
        addEntry(3'd4, 4'b0011, 1'b1);
        // Batch of zero items
        addEntry(3'd4, 4'b0000, 1'b1);
        addEntry(3'd4, 4'b0101, 1'b0);
        addEntry(3'd4, 4'b0000, 1'b0);
        addEntry(3'd4, 4'b1001, 1'b0);
        addEntry(3'd4, 4'b0000, 1'b1);
        addEntry(3'd4, 4'b1111, 1'b1);
        // More batches than the FIFO holds
        for (int k = 0; k < 20; k++) begin
            addEntry(3'd5, k[0] ? 4'b0011 : 4'b0001, 1'b1);
        end
    endtask

    task automatic buildExpected(input logic [2:0] test);
        logic [127:0] top;
        pcoeffResult_t res;
        int sumAcc;
        int countAcc;
        top = {topTable[test][3], topTable[test][2], topTable[test][1], topTable[test][0]};
        sumAcc = 0;
        countAcc = 0;
        expQ.delete();
        foreach (stimTable[n]) begin
            if (stimTable[n].test == test) begin
                for (int k = 0; k < 4; k++) begin
                    if (stimTable[n].mask[k]) begin
                        sumAcc += $countones(permuteRef(stimTable[n].bot, k == 1 || k == 3,
                            k >= 2) & top);
                        countAcc++;
                    end
                end
                if (stimTable[n].last) begin
                    res.sum = sumAcc[`PCOEFF_SUM_BITS-1:0];
                    res.count = countAcc[`PCOEFF_COUNT_BITS-1:0];
                    expQ.push_back(res);
                    expItems += countAcc;
                    expBatches++;
                    sumAcc = 0;
                    countAcc = 0;
                end
            end
        end
    endtask

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
        input logic [3:0] strb);
        axiReq.awaddr = addr;
        axiReq.wdata = data;
        axiReq.wstrb = strb;
        axiReq.awvalid = 1'b1;
        axiReq.wvalid = 1'b1;
        // Ready may follow valid combinationally
        #1;
        while (!(axiRsp.awready && axiRsp.wready)) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        axiReq.awvalid = 1'b0;
        axiReq.wvalid = 1'b0;
        while (!axiRsp.bvalid) begin
            @(negedge clk);
        end
        checkValue("write response", 64'(axiRsp.bresp), 64'd0);
        axiReq.bready = 1'b1;
        @(negedge clk);
        axiReq.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
        output logic [1:0] resp);
        axiReq.araddr = addr;
        axiReq.arvalid = 1'b1;
        #1;
        while (!axiRsp.arready) begin
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        axiReq.arvalid = 1'b0;
        while (!axiRsp.rvalid) begin
            @(negedge clk);
        end
        data = axiRsp.rdata;
        resp = axiRsp.rresp;
        axiReq.rready = 1'b1;
        @(negedge clk);
        axiReq.rready = 1'b0;
    endtask

    task automatic readCheck(input logic [7:0] addr, input logic [31:0] expected,
        input string what);
        logic [31:0] data;
        logic [1:0] resp;
        axiRead(addr, data, resp);
        checkValue(what, 64'(data), 64'(expected));
        checkValue({what, " response"}, 64'(resp), 64'd0);
    endtask

    task automatic registerTest();
        rst = 1'b1;
        repeat (10) @(negedge clk);
        checkValue("botReady in reset", 64'(botReady), 64'd0);
        rst = 1'b0;
        @(negedge clk);
        checkValue("botReady after reset", 64'(botReady), 64'd1);
        checkValue("resultsAvailable after reset", 64'(resultsAvailable), 64'd0);
        checkValue("bvalid after reset", 64'(axiRsp.bvalid), 64'd0);
        checkValue("rvalid after reset", 64'(axiRsp.rvalid), 64'd0);
        axiWrite(`REG_TOP0, 32'h1234_5678, 4'hf);
        axiWrite(`REG_TOP1, 32'h9abc_def0, 4'hf);
        axiWrite(`REG_TOP2, 32'h0f1e_2d3c, 4'hf);
        axiWrite(`REG_TOP3, 32'hcafe_f00d, 4'hf);
        readCheck(`REG_TOP0, 32'h1234_5678, "top word 0");
        readCheck(`REG_TOP1, 32'h9abc_def0, "top word 1");
        readCheck(`REG_TOP2, 32'h0f1e_2d3c, "top word 2");
        readCheck(`REG_TOP3, 32'hcafe_f00d, "top word 3");
        // Bytes 0 and 2 replaced
        axiWrite(`REG_TOP1, 32'h1111_2222, 4'b0101);
        readCheck(`REG_TOP1, 32'h9a11_de22, "top word 1 after strobes");
        readCheck(8'h20, 32'h0, "unmapped read");
        axiWrite(`REG_BOTS, 32'hffff_ffff, 4'hf);
        readCheck(`REG_BOTS, 32'h0, "bots counter after write");
    endtask

    task automatic sendEntry(input stimEntry_t e);
        int waitCycles;
        botIn.valid = 1'b1;
        botIn.bot = e.bot;
        botIn.permuteMask = e.mask;
        botIn.lastOfBatch = e.last;
        waitCycles = 0;
        while (!botReady) begin
            waitCycles++;
            // Longer than any permuter burst, so the FIFO is holding it off
            if (waitCycles >= 8) begin
                stallSeen = 1'b1;
            end
            @(negedge clk);
        end
        @(negedge clk);
        botIn.valid = 1'b0;
    endtask

    task automatic sendBatches(input logic [2:0] test);
        foreach (stimTable[n]) begin
            if (stimTable[n].test == test) begin
                sendEntry(stimTable[n]);
            end
        end
        sendDone = 1'b1;
    endtask

    task automatic receiveResults(input logic holdGrab);
        int got;
        got = 0;
        while (got < expQ.size()) begin
            @(negedge clk);
            grabResults = 1'b0;
            if (resultsAvailable && (!holdGrab || stallSeen || sendDone)) begin
                checkValue($sformatf("result %0d", got), 64'(result), 64'(expQ[got]));
                grabResults = 1'b1;
                got++;
            end
        end
        @(negedge clk);
        grabResults = 1'b0;
    endtask

    task automatic runTest(input logic [2:0] test);
        int errorsBefore;
        errorsBefore = errors;
        if (test == 3'd1) begin
            registerTest();
        end else begin
            axiWrite(`REG_TOP0, topTable[test][0], 4'hf);
            axiWrite(`REG_TOP1, topTable[test][1], 4'hf);
            axiWrite(`REG_TOP2, topTable[test][2], 4'hf);
            axiWrite(`REG_TOP3, topTable[test][3], 4'hf);
            buildExpected(test);
            stallSeen = 1'b0;
            sendDone = 1'b0;
            fork
                sendBatches(test);
                receiveResults(test == 3'd5);
            join
            // Pipeline drains within three cycles
            repeat (4) @(negedge clk);
            checkValue("resultsAvailable after drain", 64'(resultsAvailable), 64'd0);
            if (test == 3'd4) begin
                readCheck(`REG_BATCHES, 32'(expBatches), "batches counter");
                readCheck(`REG_BOTS, 32'(expItems), "bots counter");
            end
            if (test == 3'd5) begin
                checkValue("botReady stall under back-pressure", 64'(stallSeen), 64'd1);
            end
        end
        $display("Test %0d (%s): %0d errors", test, testName(test), errors - errorsBefore);
    endtask

    initial begin
        int assertFails;
        seed = 32'hfa8f_65a7;
        rst = 1'b1;
        botIn = '0;
        grabResults = 1'b0;
        axiReq = '0;
        checks = 0;
        errors = 0;
        expItems = 0;
        expBatches = 0;
        stallSeen = 1'b0;
        sendDone = 1'b0;
        buildTable();
        cycleLimit = stimTable.size() * 40;
        for (int t = 1; t <= 5; t++) begin
            runTest(3'(t));
        end
        assertFails = i_aggregatingPermutePipeline.i_aggregatingPipelineChk.failCount;
        $display("Summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
            assertFails);
        if (errors == 0 && assertFails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+hdl
hdl/pcoeffPkg.sv
hdl/botPermuter.sv
hdl/pcoeffAggregator.sv
hdl/resultFifo.sv
hdl/pcoeffConfigRegs.sv
hdl/aggregatingPermutePipeline.sv
bench/aggregatingPermutePipeline_chk.sv
bench/aggregatingPermutePipelineTb.sv

/* Makefile */
# Verilator flow for the aggregating permute pipeline

VERILATOR ?= verilator
TOP ?= aggregatingPermutePipelineTb
RTL_TOP ?= aggregatingPermutePipeline
FILELIST ?= src.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --assert --timing
SIM_ARGS ?= +verilator+error+limit+1000
PASS_MSG ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
